// ==== src.f ====
soc_pkg.sv
periph_bus_ctrl.sv
uart_tx.sv
uart_rx.sv
rx_fifo.sv
soc_ctrl_regs.sv
periph_top.sv
tb_clk_gen.sv
tb_periph_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the peripheral testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_periph_top -o sim_periph
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_periph)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
exit 1

// ==== tb_periph_top.sv ====
// peripheral subsystem testbench
// wishbone register access, uart loopback, FIFO overflow and framing error,
// all results checked by concurrent assertions on msoc_clk

`timescale 1ns/1ps

module tb_periph_top;

  import soc_pkg::*;

  localparam int    FIFO_DEPTH     = 8;
  localparam int    BIT_CLKS       = 8;      // divider for the uart tests
  localparam int    N_LOOP         = 12;
  localparam int    N_OVF          = 10;
  localparam int    POLL_LIMIT     = 100;    // status reads per wait
  localparam int    TIMEOUT_CYCLES = 20000;  // ~25 frames of 80 clocks plus polling
  localparam data_t ALL_BITS       = 32'hffff_ffff;
  localparam data_t STAT_MASK      = 32'h0000_1fff;  // head byte and status bits
  localparam data_t VALID_MASK     = data_t'(1) << ST_VALID;

  logic    msoc_clk;
  logic    rstn;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    uart_tx;
  logic    uart_rx;
  logic    tb_line;      // serial line driven by the testbench
  logic    loop_sel;     // 1 feeds rx from tx
  dip_t    dip;
  byte_t   led;

  // check requests raised on a falling edge for one cycle
  logic    rd_chk;
  addr_t   rd_adr;
  data_t   rd_got;
  data_t   rd_exp;
  data_t   rd_mask;
  logic    led_chk;
  byte_t   led_exp;
  logic    line_chk;     // tx line must idle high
  logic    no_ack;
  logic    poll_stuck;

  int      err_cnt = 0;
  int      chk_cnt = 0;
  int      cyc_cnt = 0;
  integer  seed;
  byte_t   sent_q[$];
  byte_t   b;
  data_t   tmp;
  data_t   rdummy;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(3)) u_clk_gen (
    .clk_o  (msoc_clk),
    .rstn_o (rstn)
  );

  assign uart_rx = loop_sel ? uart_tx : tb_line;  // loopback mux

  periph_top #(.RX_FIFO_DEPTH(FIFO_DEPTH), .BAUD_RESET(651)) periph_top_inst (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .wb_i      (wb_req),
    .uart_rx_i (uart_rx),
    .dip_i     (dip),
    .wb_o      (wb_rsp),
    .uart_tx_o (uart_tx),
    .led_o     (led)
  );

  //////////////////////////////////////////////////
  // checkers
  a_ack_width: assert property (@(posedge msoc_clk) disable iff (!rstn)
    wb_rsp.ack |=> !wb_rsp.ack)
    else
    begin
      err_cnt++;
      $display("t=%0t ack stayed high for two cycles", $time);
    end

  a_ack_latency: assert property (@(posedge msoc_clk) disable iff (!rstn)
    $rose(wb_req.cyc && wb_req.stb) |=> wb_rsp.ack)
    else
    begin
      err_cnt++;
      $display("t=%0t ack did not follow the request", $time);
    end

  a_ack_has_req: assert property (@(posedge msoc_clk) disable iff (!rstn)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else
    begin
      err_cnt++;
      $display("t=%0t ack without a request", $time);
    end

  a_read_data: assert property (@(posedge msoc_clk) disable iff (!rstn)
    rd_chk |-> (((rd_got ^ rd_exp) & rd_mask) == 32'h0))
    else
    begin
      err_cnt++;
      $display("ERROR t=%0t wb_o.dat adr %h got %h exp %h", $time, rd_adr,
               rd_got & rd_mask, rd_exp & rd_mask);
    end

  a_led: assert property (@(posedge msoc_clk) disable iff (!rstn)
    led_chk |-> (led == led_exp))
    else
    begin
      err_cnt++;
      $display("ERROR t=%0t led_o got %h exp %h", $time, led, led_exp);
    end

  a_line_idle: assert property (@(posedge msoc_clk) disable iff (!rstn)
    line_chk |-> uart_tx)
    else
    begin
      err_cnt++;
      $display("ERROR t=%0t uart_tx_o got %b exp 1", $time, uart_tx);
    end

  a_no_ack: assert property (@(posedge msoc_clk) disable iff (!rstn) !no_ack)
    else
    begin
      err_cnt++;
      $display("t=%0t request got no ack in 4 cycles", $time);
    end

  a_poll: assert property (@(posedge msoc_clk) disable iff (!rstn) !poll_stuck)
    else
    begin
      err_cnt++;
      $display("t=%0t status bit never reached its value", $time);
    end

  //////////////////////////////////////////////////
  // bus helpers
  function automatic addr_t reg_addr(input slot_t slot, input reg_off_t off);
    return {8'h00, slot, 14'h0000, off, 2'b00};
  endfunction

  // status word as the head entry should show it with both busy bits clear
  function automatic data_t status_exp(input byte_t data, input logic err, input logic full);
    data_t w;
    w           = '0;
    w[7:0]      = data;
    w[ST_VALID] = 1'b1;
    w[ST_ERR]   = err;
    w[ST_FULL]  = full;
    return w;
  endfunction

  task automatic bus_cycle(input logic we, input addr_t adr, input data_t wdat,
                           output data_t rdat);
    int waited;
    waited = 0;
    @(negedge msoc_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.sel = 4'hf;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do
    begin
      @(negedge msoc_clk);
      waited++;
    end
    while (!wb_rsp.ack && waited < 4);
    rdat   = wb_rsp.dat;
    no_ack = ~wb_rsp.ack;
    wb_req = '0;              // stb dropped in the ack cycle
    @(negedge msoc_clk);
    no_ack = 1'b0;
  endtask

  // read kept up over the ack edge, a second ack would be a double accept
  task automatic held_read(input addr_t adr, output data_t rdat);
    @(negedge msoc_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.sel = 4'hf;
    wb_req.adr = adr;
    wb_req.dat = '0;
    @(negedge msoc_clk);      // ack due one cycle after the request
    rdat   = wb_rsp.dat;
    no_ack = ~wb_rsp.ack;
    @(negedge msoc_clk);      // still held across the ack edge
    no_ack = 1'b0;
    wb_req = '0;
  endtask

  task automatic data_check(input addr_t adr, input data_t got, input data_t exp,
                            input data_t mask);
    rd_adr  = adr;
    rd_got  = got;
    rd_exp  = exp;
    rd_mask = mask;
    rd_chk  = 1'b1;
    chk_cnt++;
    @(negedge msoc_clk);
    rd_chk = 1'b0;
  endtask

  task automatic read_check(input addr_t adr, input data_t exp, input data_t mask);
    data_t got;
    bus_cycle(1'b0, adr, '0, got);
    data_check(adr, got, exp, mask);
  endtask

  task automatic pins_check(input byte_t exp_led);
    led_exp  = exp_led;
    led_chk  = 1'b1;
    line_chk = 1'b1;
    chk_cnt += 2;
    @(negedge msoc_clk);
    led_chk  = 1'b0;
    line_chk = 1'b0;
  endtask

  // poll the FIFO status word until one bit reads val
  task automatic wait_status(input int pos, input logic val);
    data_t st;
    int    tries;
    tries = 0;
    do
    begin
      bus_cycle(1'b0, reg_addr(SLOT_RXFIFO, '0), '0, st);
      tries++;
    end
    while (st[pos] !== val && tries < POLL_LIMIT);
    if (st[pos] !== val)
    begin
      poll_stuck = 1'b1;
      @(negedge msoc_clk);
      poll_stuck = 1'b0;
    end
  endtask

  task automatic send_byte(input byte_t data);
    data_t unused;
    bus_cycle(1'b1, reg_addr(SLOT_UART, OFF_TXDATA), data_t'(data), unused);
    wait_status(ST_TXBUSY, 1'b0);
    wait_status(ST_RXBUSY, 1'b0);  // receiver finishes just after tx
  endtask

  task automatic pop_entry();
    data_t unused;
    bus_cycle(1'b1, reg_addr(SLOT_RXFIFO, '0), '0, unused);
  endtask

  // 8n1 frame on the testbench line with the stop bit level chosen by the caller
  task automatic drive_frame(input byte_t data, input logic stop);
    logic [9:0] bits;
    bits = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      tb_line = bits[i];
      repeat (BIT_CLKS) @(negedge msoc_clk);
    end
    tb_line = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  initial
  begin
    seed       = 32'h22e37ddc;
    wb_req     = '0;
    dip        = '0;
    tb_line    = 1'b1;
    loop_sel   = 1'b1;
    rd_chk     = 1'b0;
    rd_adr     = '0;
    rd_got     = '0;
    rd_exp     = '0;
    rd_mask    = '0;
    led_chk    = 1'b0;
    led_exp    = '0;
    line_chk   = 1'b0;
    no_ack     = 1'b0;
    poll_stuck = 1'b0;
    @(posedge rstn);
    @(negedge msoc_clk);

    // reset values
    pins_check(8'h00);
    read_check(reg_addr(SLOT_UART, OFF_BAUD), 32'd651, ALL_BITS);
    read_check(reg_addr(SLOT_RXFIFO, '0), '0, VALID_MASK);

    // unmapped slot and offset read as zero
    read_check(reg_addr(4'd5, '0), '0, ALL_BITS);
    read_check(reg_addr(SLOT_UART, 4'd2), '0, ALL_BITS);

    // request held through its ack still gets one ack
    held_read(reg_addr(SLOT_UART, OFF_BAUD), tmp);
    data_check(reg_addr(SLOT_UART, OFF_BAUD), tmp, 32'd651, ALL_BITS);

    // board io
    tmp = $random(seed);
    bus_cycle(1'b1, reg_addr(SLOT_BOARD, '0), tmp, rdummy);
    pins_check(tmp[7:0]);
    dip = dip_t'($random(seed));
    repeat (3) @(negedge msoc_clk);     // two sync stages
    read_check(reg_addr(SLOT_BOARD, '0), data_t'(dip), ALL_BITS);

    // loopback at a short divider
    bus_cycle(1'b1, reg_addr(SLOT_UART, OFF_BAUD), data_t'(BIT_CLKS), rdummy);
    read_check(reg_addr(SLOT_UART, OFF_BAUD), data_t'(BIT_CLKS), ALL_BITS);
    for (int i = 0; i < N_LOOP; i++)
    begin
      b = byte_t'($random(seed));
      send_byte(b);
      read_check(reg_addr(SLOT_RXFIFO, '0), status_exp(b, 1'b0, 1'b0), STAT_MASK);
      pop_entry();
    end
    read_check(reg_addr(SLOT_RXFIFO, '0), '0, VALID_MASK);

    // overflow with no pops until all bytes are sent
    for (int i = 0; i < N_OVF; i++)
    begin
      b = byte_t'($random(seed));
      sent_q.push_back(b);
      send_byte(b);
    end
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      read_check(reg_addr(SLOT_RXFIFO, '0), status_exp(sent_q[i], 1'b0, i == 0), STAT_MASK);
      pop_entry();
    end
    read_check(reg_addr(SLOT_RXFIFO, '0), '0, VALID_MASK);  // last two dropped

    // framing error from a low stop bit
    b        = byte_t'($random(seed));
    loop_sel = 1'b0;
    drive_frame(b, 1'b0);
    wait_status(ST_RXBUSY, 1'b0);
    read_check(reg_addr(SLOT_RXFIFO, '0), status_exp(b, 1'b1, 1'b0), STAT_MASK);
    pop_entry();
    read_check(reg_addr(SLOT_RXFIFO, '0), '0, VALID_MASK);

    @(negedge msoc_clk);
    $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // run limit
  always @(posedge msoc_clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the test sequence did not complete", cyc_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock and reset
// free running msoc_clk and an active low reset held for RST_CYCLES clocks

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rstn_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // released on a falling edge away from the sampling edge
  initial
  begin
    rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule

// ==== periph_top.sv ====
// peripheral subsystem top
// wishbone controller with the uart, receive FIFO and board registers

`timescale 1ns/1ps

module periph_top #(
  parameter int          RX_FIFO_DEPTH = 8,
  parameter int unsigned BAUD_RESET    = 651
) (
  input  logic             msoc_clk,
  input  logic             rstn,
  input  soc_pkg::wb_req_t wb_i,
  input  logic             uart_rx_i,
  input  soc_pkg::dip_t    dip_i,
  output soc_pkg::wb_rsp_t wb_o,
  output logic             uart_tx_o,
  output soc_pkg::byte_t   led_o
);

  import soc_pkg::*;

  data_t     wdata;
  baud_div_t baud;
  dip_t      dip_sync;
  rx_entry_t rx_entry;      // receiver to FIFO
  rx_entry_t fifo_head;
  logic      tx_start, baud_we, led_we, rx_pop;
  logic      tx_busy, rx_busy, rx_push;
  logic      fifo_empty, fifo_full;

  periph_bus_ctrl u_bus_ctrl (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .wb_i         (wb_i),
    .baud_i       (baud),
    .fifo_head_i  (fifo_head),
    .fifo_empty_i (fifo_empty),
    .fifo_full_i  (fifo_full),
    .tx_busy_i    (tx_busy),
    .rx_busy_i    (rx_busy),
    .dip_i        (dip_sync),
    .wb_o         (wb_o),
    .wdata_o      (wdata),
    .tx_start_o   (tx_start),
    .baud_we_o    (baud_we),
    .led_we_o     (led_we),
    .rx_pop_o     (rx_pop)
  );

  uart_tx u_uart_tx (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .start_i  (tx_start),
    .data_i   (wdata[7:0]),
    .baud_i   (baud),
    .tx_o     (uart_tx_o),
    .busy_o   (tx_busy)
  );

  uart_rx u_uart_rx (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .rx_i     (uart_rx_i),
    .baud_i   (baud),
    .entry_o  (rx_entry),
    .push_o   (rx_push),
    .busy_o   (rx_busy)
  );

  rx_fifo #(.RX_FIFO_DEPTH(RX_FIFO_DEPTH)) u_rx_fifo (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .push_i   (rx_push),
    .entry_i  (rx_entry),
    .pop_i    (rx_pop),
    .head_o   (fifo_head),
    .empty_o  (fifo_empty),
    .full_o   (fifo_full)
  );

  soc_ctrl_regs #(.BAUD_RESET(BAUD_RESET)) u_ctrl_regs (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .led_we_i   (led_we),
    .baud_we_i  (baud_we),
    .wdata_i    (wdata),
    .dip_i      (dip_i),
    .led_o      (led_o),
    .baud_o     (baud),
    .dip_sync_o (dip_sync)
  );

endmodule

// ==== soc_ctrl_regs.sv ====
// board control registers
// led byte, uart baud divider and a two stage dip switch synchroniser

`timescale 1ns/1ps

module soc_ctrl_regs #(
  parameter int unsigned BAUD_RESET = 651
) (
  input  logic               msoc_clk,
  input  logic               rstn,
  input  logic               led_we_i,
  input  logic               baud_we_i,
  input  soc_pkg::data_t     wdata_i,
  input  soc_pkg::dip_t      dip_i,
  output soc_pkg::byte_t     led_o,
  output soc_pkg::baud_div_t baud_o,
  output soc_pkg::dip_t      dip_sync_o
);

  import soc_pkg::*;

  byte_t     led_q;
  baud_div_t baud_q;
  dip_t      dip_s1;      // first stage, may be metastable
  dip_t      dip_s2;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_q  <= '0;
      baud_q <= baud_div_t'(BAUD_RESET);
      dip_s1 <= '0;
      dip_s2 <= '0;
    end
    else
    begin
      if (led_we_i)
        led_q <= wdata_i[7:0];
      if (baud_we_i)
        baud_q <= wdata_i[15:0];   // clocks per bit
      dip_s1 <= dip_i;
      dip_s2 <= dip_s1;
    end
  end

  assign led_o      = led_q;
  assign baud_o     = baud_q;
  assign dip_sync_o = dip_s2;

endmodule

// ==== rx_fifo.sv ====
// receive FIFO
// circular buffer of uart entries, push from the receiver,
// pop on a bus write, head entry always visible

`timescale 1ns/1ps

module rx_fifo #(
  parameter int RX_FIFO_DEPTH = 8
) (
  input  logic               msoc_clk,
  input  logic               rstn,
  input  logic               push_i,
  input  soc_pkg::rx_entry_t entry_i,
  input  logic               pop_i,
  output soc_pkg::rx_entry_t head_o,
  output logic               empty_o,
  output logic               full_o
);

  import soc_pkg::*;

  localparam int PTR_W = (RX_FIFO_DEPTH > 1) ? $clog2(RX_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(RX_FIFO_DEPTH + 1);

  rx_entry_t        mem [RX_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(RX_FIFO_DEPTH));
  assign do_push = push_i & ~full_o;   // entry dropped when full
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(RX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(RX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= entry_i;
  end

  assign head_o = mem[rd_ptr];

  a_count_bound: assert property (@(posedge msoc_clk) disable iff (!rstn)
    count <= CNT_W'(RX_FIFO_DEPTH));

endmodule

// ==== uart_rx.sv ====
// uart receiver
// two flop synchroniser and 3-sample majority vote on the rx line,
// mid-bit sampling of an 8n1 frame, low stop bit flags a framing error

`timescale 1ns/1ps

module uart_rx (
  input  logic               msoc_clk,
  input  logic               rstn,
  input  logic               rx_i,
  input  soc_pkg::baud_div_t baud_i,
  output soc_pkg::rx_entry_t entry_o,
  output logic               push_o,
  output logic               busy_o
);

  import soc_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e  state_q;
  logic [1:0] sync_q;       // metastability flops
  logic [2:0] samp_q;       // last three samples
  logic       maj_q;
  logic       maj_d;        // for edge detect
  baud_div_t  cnt_q;
  logic [2:0] bit_cnt;
  byte_t      shift_q;
  rx_entry_t  entry_q;
  logic       push_q;
  logic       half_end;
  logic       bit_end;

  assign half_end = (cnt_q == {1'b0, baud_i[15:1]} - 16'd1);
  assign bit_end  = (cnt_q == baud_i - 16'd1);

  //////////////////////////////////////////////////
  // line filter, resets to idle high
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sync_q <= 2'b11;
      samp_q <= 3'b111;
      maj_q  <= 1'b1;
      maj_d  <= 1'b1;
    end
    else
    begin
      sync_q <= {sync_q[0], rx_i};
      samp_q <= {samp_q[1:0], sync_q[1]};
      maj_q  <= (samp_q[0] & samp_q[1]) | (samp_q[0] & samp_q[2]) | (samp_q[1] & samp_q[2]);
      maj_d  <= maj_q;
    end
  end

  //////////////////////////////////////////////////
  // frame FSM
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_cnt <= '0;
      push_q  <= 1'b0;
    end
    else
    begin
      push_q <= 1'b0;
      cnt_q  <= cnt_q + 16'd1;
      case (state_q)
        RX_IDLE:
        begin
          cnt_q <= '0;
          if (maj_d && !maj_q)     // falling edge, not a held low line
            state_q <= RX_START;
        end
        RX_START:
          if (half_end)            // mid start bit
          begin
            cnt_q   <= '0;
            bit_cnt <= '0;
            state_q <= maj_q ? RX_IDLE : RX_DATA;  // glitch back to idle
          end
        RX_DATA:
          if (bit_end)
          begin
            cnt_q   <= '0;
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
              state_q <= RX_STOP;
          end
        default:
          if (bit_end)             // mid stop bit
          begin
            push_q  <= 1'b1;
            state_q <= RX_IDLE;
          end
      endcase
    end
  end

  // payload, lsb first
  always_ff @(posedge msoc_clk)
  begin
    if (state_q == RX_DATA && bit_end)
      shift_q <= {maj_q, shift_q[7:1]};
    if (state_q == RX_STOP && bit_end)
      entry_q <= '{err: ~maj_q, data: shift_q};
  end

  assign entry_o = entry_q;
  assign push_o  = push_q;
  assign busy_o  = (state_q != RX_IDLE);

  a_push_pulse: assert property (@(posedge msoc_clk) disable iff (!rstn)
    push_o |=> !push_o);

endmodule

// ==== uart_tx.sv ====
// uart transmitter
// 8n1 frame, one start bit, 8 data bits lsb first, one stop bit,
// each bit held for baud_i clocks

`timescale 1ns/1ps

module uart_tx (
  input  logic               msoc_clk,
  input  logic               rstn,
  input  logic               start_i,
  input  soc_pkg::byte_t     data_i,
  input  soc_pkg::baud_div_t baud_i,
  output logic               tx_o,
  output logic               busy_o
);

  import soc_pkg::*;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e state_q;
  baud_div_t div_cnt;       // clocks into current bit
  logic [2:0] bit_cnt;
  byte_t     shift_q;
  logic      tx_q;
  logic      bit_end;

  assign bit_end = (div_cnt == baud_i - 16'd1);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q <= TX_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      tx_q    <= 1'b1;      // line idles high
    end
    else
    begin
      div_cnt <= bit_end ? '0 : div_cnt + 16'd1;
      case (state_q)
        TX_IDLE:
        begin
          div_cnt <= '0;
          if (start_i)      // start ignored while busy
          begin
            state_q <= TX_START;
            tx_q    <= 1'b0;
          end
        end
        TX_START:
          if (bit_end)
          begin
            state_q <= TX_DATA;
            bit_cnt <= '0;
            tx_q    <= shift_q[0];
          end
        TX_DATA:
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
              state_q <= TX_STOP;
              tx_q    <= 1'b1;
            end
            else
              tx_q <= shift_q[bit_cnt + 3'd1];
          end
        default:            // stop bit
          if (bit_end)
            state_q <= TX_IDLE;
      endcase
    end
  end

  // byte latched on start
  always_ff @(posedge msoc_clk)
  begin
    if (start_i && state_q == TX_IDLE)
      shift_q <= data_i;
  end

  assign tx_o   = tx_q;
  assign busy_o = (state_q != TX_IDLE);

endmodule

// ==== periph_bus_ctrl.sv ====
// peripheral bus controller
// wishbone classic slave, one-hot slot decode on adr[23:20],
// single cycle write strobes and a registered read mux with ack

`timescale 1ns/1ps

module periph_bus_ctrl (
  input  logic               msoc_clk,
  input  logic               rstn,
  input  soc_pkg::wb_req_t   wb_i,
  input  soc_pkg::baud_div_t baud_i,
  input  soc_pkg::rx_entry_t fifo_head_i,
  input  logic               fifo_empty_i,
  input  logic               fifo_full_i,
  input  logic               tx_busy_i,
  input  logic               rx_busy_i,
  input  soc_pkg::dip_t      dip_i,
  output soc_pkg::wb_rsp_t   wb_o,
  output soc_pkg::data_t     wdata_o,
  output logic               tx_start_o,
  output logic               baud_we_o,
  output logic               led_we_o,
  output logic               rx_pop_o
);

  import soc_pkg::*;

  slot_t      slot;
  reg_off_t   off;
  logic [15:0] slot_oh;         // one bit per slot
  logic       accept;
  logic       wr_acc;
  logic       ack_q;
  data_t      rdat_q;
  data_t      rdata;            // read mux result
  data_t      status_word;
  data_t      slot_rdata [16];

  assign slot = wb_i.adr[23:20];
  assign off  = wb_i.adr[5:2];

  // a request still held while ack is out is the same request
  assign accept = wb_i.cyc & wb_i.stb & ~ack_q;
  assign wr_acc = accept & wb_i.we;

  //////////////////////////////////////////////////
  // write strobes, one cycle, in the accept cycle
  assign tx_start_o = wr_acc & slot_oh[SLOT_UART] & (off == OFF_TXDATA);
  assign baud_we_o  = wr_acc & slot_oh[SLOT_UART] & (off == OFF_BAUD);
  assign led_we_o   = wr_acc & slot_oh[SLOT_BOARD];
  assign rx_pop_o   = wr_acc & slot_oh[SLOT_RXFIFO];  // data ignored
  assign wdata_o    = wb_i.dat;

  // FIFO status word, upper bits zero
  always_comb
  begin
    status_word            = '0;
    status_word[7:0]       = fifo_head_i.data;
    status_word[ST_VALID]  = ~fifo_empty_i;
    status_word[ST_TXBUSY] = tx_busy_i;
    status_word[ST_RXBUSY] = rx_busy_i;
    status_word[ST_ERR]    = fifo_head_i.err;
    status_word[ST_FULL]   = fifo_full_i;
  end

  //////////////////////////////////////////////////
  // per slot read data, then or them together
  always_comb
  begin
    for (int s = 0; s < 16; s++)
    begin
      slot_rdata[s] = '0;            // unmapped reads as zero
    end
    slot_rdata[SLOT_UART]   = (off == OFF_BAUD) ? data_t'(baud_i) : '0;
    slot_rdata[SLOT_RXFIFO] = status_word;  // read does not pop
    slot_rdata[SLOT_BOARD]  = data_t'(dip_i);
    rdata = '0;
    for (int i = 0; i < 16; i++)
    begin
      slot_oh[i] = (slot == slot_t'(i));
      rdata     |= slot_oh[i] ? slot_rdata[i] : '0;
    end
  end

  // ack one clock after the request is seen
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
      ack_q <= 1'b0;
    else
      ack_q <= accept;
  end

  // read data rides with ack
  always_ff @(posedge msoc_clk)
  begin
    if (accept)
      rdat_q <= rdata;
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdat_q;

  // no back to back acks, a held request must not be taken twice
  a_ack_single: assert property (@(posedge msoc_clk) disable iff (!rstn)
    wb_o.ack |=> !wb_o.ack);

endmodule

// ==== soc_pkg.sv ====
// soc peripheral package
// shared widths, slot map, wishbone bus structs and the uart receive entry
// used by the bus controller, the uart blocks and the receive FIFO

package soc_pkg;

  //////////////////////////////////////////////////
  // basic types
  typedef logic [31:0] addr_t;     // wishbone byte address
  typedef logic [31:0] data_t;     // bus data word
  typedef logic [3:0]  slot_t;     // adr[23:20]
  typedef logic [3:0]  reg_off_t;  // adr[5:2], word offset in slot
  typedef logic [7:0]  byte_t;     // uart data, led byte
  typedef logic [15:0] baud_div_t; // clocks per bit
  typedef logic [15:0] dip_t;      // dip switches

  // one receive FIFO entry with the error flag on top
  typedef struct packed {
    logic  err;   // stop bit was low
    byte_t data;
  } rx_entry_t;

  //////////////////////////////////////////////////
  // wishbone classic request from master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [3:0] sel;
    addr_t      adr;
    data_t      dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_rsp_t;

  //////////////////////////////////////////////////
  // slot map
  localparam slot_t    SLOT_UART   = 4'd2;  // tx data and baud
  localparam slot_t    SLOT_RXFIFO = 4'd3;  // receive FIFO
  localparam slot_t    SLOT_BOARD  = 4'd7;  // led and dip
  localparam reg_off_t OFF_TXDATA  = 4'd0;
  localparam reg_off_t OFF_BAUD    = 4'd1;

  // bit positions in the FIFO status word above the head byte in [7:0]
  localparam int ST_VALID  = 8;
  localparam int ST_TXBUSY = 9;
  localparam int ST_RXBUSY = 10;
  localparam int ST_ERR    = 11;
  localparam int ST_FULL   = 12;

endpackage
